//--- bpu_cfg_pkg.sv
package bpu_cfg_pkg;

    // --------------------
    // address geometry
    // --------------------

    localparam int vaddr_size = 32;

    // log2 of the instruction size, every instruction is 4 bytes
    localparam int inst_offset = 2;

    // --------------------
    // fetch block geometry
    // --------------------

    localparam int block_size = 32;
    localparam int block_inst_size = 8;

    // instruction index inside one block
    localparam int prediction_width = 3;

    // --------------------
    // slots and table
    // --------------------

    // one ordinary branch slot plus the tail slot
    localparam int slot_num = 2;

    localparam int ubtb_size = 16;
    localparam int ubtb_tag_size = 8;
    localparam int ubtb_idx_w = 4;

    // low target bits kept per slot, the rest comes from the pc
    localparam int jal_offset = 12;
    localparam int jalr_offset = 20;

endpackage

//--- bpu_types_pkg.sv
package bpu_types_pkg;

    // kind of control transfer held by a slot
    typedef enum logic [2:0] {
        br_cond,
        br_direct,
        br_call,
        br_ret,
        br_indirect
    } br_type_e;

    // correction applied to the upper pc bits when a target is rebuilt
    typedef enum logic [1:0] {
        tar_normal,
        tar_ov,
        tar_un
    } tar_state_e;

endpackage

//--- ubtb_replace.sv
`timescale 1ns/100ps

module ubtb_replace (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [bpu_cfg_pkg::ubtb_size-1:0]    valid,
    output logic [bpu_cfg_pkg::ubtb_idx_w-1:0]   victim
);

    logic [15:0]                        lfsr;
    logic [bpu_cfg_pkg::ubtb_idx_w-1:0] free_idx;

    // x^16 + x^14 + x^13 + x^11 + 1, steps every cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // scan from the top so the lowest free way is the one left standing
    always_comb begin
        free_idx = '0;
        for (int i = bpu_cfg_pkg::ubtb_size - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = i[bpu_cfg_pkg::ubtb_idx_w-1:0];
            end
        end
    end

    assign victim = (&valid) ? lfsr[bpu_cfg_pkg::ubtb_idx_w-1:0] : free_idx;

    // an all-zero state would lock the sequence for good
    a_lfsr_nonzero: assert property (@(posedge clk) disable iff (rst) lfsr != '0)
        else $error("replacement lfsr reached zero");

endmodule

//--- ubtb_predict.sv
`timescale 1ns/100ps

module ubtb_predict (
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]        pc,
    input  logic                                      hit,
    input  logic [bpu_cfg_pkg::prediction_width-1:0]  fth_addr,
    input  logic                                      br_en,
    input  logic                                      br_carry,
    input  logic [bpu_cfg_pkg::prediction_width-1:0]  br_offset,
    input  logic [bpu_cfg_pkg::jal_offset-1:0]        br_target,
    input  bpu_types_pkg::tar_state_e                 br_tar_state,
    input  logic                                      tail_en,
    input  logic                                      tail_carry,
    input  bpu_types_pkg::br_type_e                   tail_type,
    input  logic [bpu_cfg_pkg::prediction_width-1:0]  tail_offset,
    input  logic [bpu_cfg_pkg::jalr_offset-1:0]       tail_target,
    input  bpu_types_pkg::tar_state_e                 tail_tar_state,
    input  logic [bpu_cfg_pkg::slot_num-1:0][1:0]     ctr,
    input  logic                                      redirect_flush,
    input  logic                                      s2_redirect,
    input  logic                                      tage_ready,
    output logic                                      pred_en,
    output logic                                      pred_hit,
    output logic                                      pred_taken,
    output logic [bpu_cfg_pkg::vaddr_size-1:0]        pred_target,
    output logic [bpu_cfg_pkg::prediction_width-1:0]  pred_size,
    output bpu_types_pkg::br_type_e                   pred_br_type,
    output logic [1:0]                                pred_cond_num,
    output logic [bpu_cfg_pkg::slot_num-1:0]          pred_cond_valid,
    output logic [bpu_cfg_pkg::slot_num-1:0]          pred_slot_taken,
    output logic [bpu_cfg_pkg::slot_num-1:0][1:0]     meta_ctr
);

    logic [bpu_cfg_pkg::slot_num-1:0]                          is_br;
    logic [bpu_cfg_pkg::slot_num-1:0]                          carry;
    logic [bpu_cfg_pkg::slot_num-1:0]                          cond_hist;
    logic [bpu_cfg_pkg::slot_num-1:0]                          br_takens;
    logic                                                      tail_taken;
    logic                                                      tail_first;
    logic [bpu_cfg_pkg::jal_offset-1:0]                        sel_offset;
    logic [bpu_cfg_pkg::prediction_width-1:0]                  sel_size;
    bpu_types_pkg::tar_state_e                                 sel_state;
    logic [1:0]                                                cond_num;
    logic [bpu_cfg_pkg::slot_num-1:0]                          cond_valid;
    logic [bpu_cfg_pkg::vaddr_size-bpu_cfg_pkg::jal_offset-2:0]  br_high;
    logic [bpu_cfg_pkg::vaddr_size-bpu_cfg_pkg::jalr_offset-2:0] tail_high;
    logic [bpu_cfg_pkg::prediction_width:0]                    fth_next;
    logic [bpu_cfg_pkg::vaddr_size-1:0]                        br_target_full;
    logic [bpu_cfg_pkg::vaddr_size-1:0]                        tail_target_full;
    logic [bpu_cfg_pkg::prediction_width-1:0]                  tail_size;

    // --------------------
    // slot directions
    // --------------------

    assign is_br = {tail_en && tail_type == bpu_types_pkg::br_cond, br_en};
    assign carry = {tail_carry, br_carry};
    assign cond_hist = {ctr[1][1], ctr[0][1]};
    assign br_takens = is_br & (cond_hist | carry);

    // a tail jump is taken unconditionally
    assign tail_taken = tail_en && tail_type != bpu_types_pkg::br_cond;

    // the tail conditional only wins over a branch at a strictly larger offset
    assign tail_first = br_takens[1] && (br_offset > tail_offset);

    always_comb begin
        if (tail_first || !br_takens[0]) begin
            sel_offset = tail_target[bpu_cfg_pkg::jal_offset-1:0];
            sel_size = tail_offset;
            sel_state = tail_tar_state;
        end else begin
            sel_offset = br_target;
            sel_size = br_offset;
            sel_state = br_tar_state;
        end
        if (tail_first) begin
            cond_num = 2'd1;
            cond_valid = 2'b10;
        end else begin
            cond_num = is_br[0] + is_br[1];
            cond_valid = is_br;
        end
    end

    // --------------------
    // target rebuild
    // --------------------

    assign br_high = (sel_state == bpu_types_pkg::tar_ov) ?
                         pc[bpu_cfg_pkg::vaddr_size-1:bpu_cfg_pkg::jal_offset+1] + 1'b1 :
                     (sel_state == bpu_types_pkg::tar_un) ?
                         pc[bpu_cfg_pkg::vaddr_size-1:bpu_cfg_pkg::jal_offset+1] - 1'b1 :
                         pc[bpu_cfg_pkg::vaddr_size-1:bpu_cfg_pkg::jal_offset+1];

    assign tail_high = (tail_tar_state == bpu_types_pkg::tar_ov) ?
                           pc[bpu_cfg_pkg::vaddr_size-1:bpu_cfg_pkg::jalr_offset+1] + 1'b1 :
                       (tail_tar_state == bpu_types_pkg::tar_un) ?
                           pc[bpu_cfg_pkg::vaddr_size-1:bpu_cfg_pkg::jalr_offset+1] - 1'b1 :
                           pc[bpu_cfg_pkg::vaddr_size-1:bpu_cfg_pkg::jalr_offset+1];

    assign fth_next = {1'b0, fth_addr} + 1'b1;
    assign br_target_full = {br_high, sel_offset, 1'b0};

    // with nothing taken the block falls through past fth_addr
    assign tail_target_full = tail_taken ? {tail_high, tail_target, 1'b0} :
                              pc + {fth_next, {bpu_cfg_pkg::inst_offset{1'b0}}};
    assign tail_size = tail_taken ? tail_offset : fth_addr;

    // --------------------
    // outputs
    // --------------------

    assign pred_en = !redirect_flush && !s2_redirect && tage_ready;
    assign pred_hit = hit;
    assign pred_taken = hit && ((|br_takens) || tail_taken);
    assign pred_target = !hit ? pc + bpu_cfg_pkg::block_size :
                         (|br_takens) ? br_target_full : tail_target_full;
    assign pred_size = !hit ? bpu_cfg_pkg::prediction_width'(bpu_cfg_pkg::block_inst_size - 1) :
                       (|br_takens) ? sel_size : tail_size;
    assign pred_br_type = (|br_takens) ? bpu_types_pkg::br_cond : tail_type;
    assign pred_cond_num = hit ? cond_num : 2'd0;
    assign pred_cond_valid = hit ? cond_valid : '0;
    assign pred_slot_taken = hit ? br_takens : '0;
    assign meta_ctr = ctr;

    // stored targets drop bit 0, so a hit must still land on a word boundary
    a_target_aligned: assert final (pred_hit !== 1'b1 || pred_target[1:0] == 2'b00)
        else $error("misaligned predicted target %h", pred_target);

endmodule

//--- ubtb.sv
`timescale 1ns/100ps

module ubtb (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]        pc,
    input  logic                                      redirect_flush,
    input  logic                                      s2_redirect,
    input  logic                                      tage_ready,
    input  logic                                      update,
    input  logic [bpu_cfg_pkg::vaddr_size-1:0]        upd_start_addr,
    input  logic                                      upd_en,
    input  logic [bpu_cfg_pkg::prediction_width-1:0]  upd_fth_addr,
    input  logic                                      upd_br_en,
    input  logic                                      upd_br_carry,
    input  logic [bpu_cfg_pkg::prediction_width-1:0]  upd_br_offset,
    input  logic [bpu_cfg_pkg::jal_offset-1:0]        upd_br_target,
    input  bpu_types_pkg::tar_state_e                 upd_br_tar_state,
    input  logic                                      upd_tail_en,
    input  logic                                      upd_tail_carry,
    input  bpu_types_pkg::br_type_e                   upd_tail_type,
    input  logic [bpu_cfg_pkg::prediction_width-1:0]  upd_tail_offset,
    input  logic [bpu_cfg_pkg::jalr_offset-1:0]       upd_tail_target,
    input  bpu_types_pkg::tar_state_e                 upd_tail_tar_state,
    input  logic [bpu_cfg_pkg::slot_num-1:0][1:0]     upd_meta_ctr,
    input  logic [bpu_cfg_pkg::slot_num-1:0]          upd_real_taken,
    input  logic [bpu_cfg_pkg::slot_num-1:0]          upd_alloc_slot,
    output logic                                      pred_en,
    output logic                                      pred_hit,
    output logic                                      pred_taken,
    output logic [bpu_cfg_pkg::vaddr_size-1:0]        pred_target,
    output logic [bpu_cfg_pkg::prediction_width-1:0]  pred_size,
    output bpu_types_pkg::br_type_e                   pred_br_type,
    output logic [1:0]                                pred_cond_num,
    output logic [bpu_cfg_pkg::slot_num-1:0]          pred_cond_valid,
    output logic [bpu_cfg_pkg::slot_num-1:0]          pred_slot_taken,
    output logic [bpu_cfg_pkg::slot_num-1:0][1:0]     meta_ctr
);

    typedef struct packed {
        logic [bpu_cfg_pkg::prediction_width-1:0] fth_addr;
        logic                                     br_en;
        logic                                     br_carry;
        logic [bpu_cfg_pkg::prediction_width-1:0] br_offset;
        logic [bpu_cfg_pkg::jal_offset-1:0]       br_target;
        bpu_types_pkg::tar_state_e                br_tar_state;
        logic                                     tail_en;
        logic                                     tail_carry;
        bpu_types_pkg::br_type_e                  tail_type;
        logic [bpu_cfg_pkg::prediction_width-1:0] tail_offset;
        logic [bpu_cfg_pkg::jalr_offset-1:0]      tail_target;
        bpu_types_pkg::tar_state_e                tail_tar_state;
    } entry_t;

    logic [bpu_cfg_pkg::ubtb_size-1:0]           ent_valid;
    logic [bpu_cfg_pkg::ubtb_tag_size-1:0]       ent_tag [bpu_cfg_pkg::ubtb_size];
    entry_t                                      entries [bpu_cfg_pkg::ubtb_size];
    logic [bpu_cfg_pkg::slot_num-1:0][1:0]       ctrs [bpu_cfg_pkg::ubtb_size];

    logic [bpu_cfg_pkg::ubtb_tag_size-1:0]       lookup_tag;
    logic [bpu_cfg_pkg::ubtb_tag_size-1:0]       update_tag;
    logic [bpu_cfg_pkg::ubtb_size-1:0]           lookup_hits;
    logic [bpu_cfg_pkg::ubtb_size-1:0]           upd_hits;
    entry_t                                      lk_entry;
    logic [bpu_cfg_pkg::slot_num-1:0][1:0]       lk_ctr;
    entry_t                                      upd_entry;
    logic [bpu_cfg_pkg::ubtb_idx_w-1:0]          upd_idx;
    logic [bpu_cfg_pkg::ubtb_idx_w-1:0]          victim;
    logic [bpu_cfg_pkg::ubtb_idx_w-1:0]          write_idx;
    logic [bpu_cfg_pkg::slot_num-1:0]            train;

    // xor-fold every pc bit above the block offset into the tag
    function automatic logic [bpu_cfg_pkg::ubtb_tag_size-1:0] fold_tag(
        input logic [bpu_cfg_pkg::vaddr_size-1:0] addr
    );
        logic [bpu_cfg_pkg::ubtb_tag_size-1:0] t;
        int base;
        t = '0;
        base = bpu_cfg_pkg::prediction_width + bpu_cfg_pkg::inst_offset;
        for (int i = base; i < bpu_cfg_pkg::vaddr_size; i++) begin
            t[(i - base) % bpu_cfg_pkg::ubtb_tag_size] ^= addr[i];
        end
        return t;
    endfunction

    // 2-bit saturating counter step
    function automatic logic [1:0] sat_ctr(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // --------------------
    // lookup
    // --------------------

    assign lookup_tag = fold_tag(pc);
    assign update_tag = fold_tag(upd_start_addr);

    always_comb begin
        for (int i = 0; i < bpu_cfg_pkg::ubtb_size; i++) begin
            lookup_hits[i] = ent_valid[i] && ent_tag[i] == lookup_tag;
            upd_hits[i] = ent_valid[i] && ent_tag[i] == update_tag;
        end
    end

    // and-or select, so a miss presents an all-zero entry
    always_comb begin
        lk_entry = '0;
        lk_ctr = '0;
        for (int i = 0; i < bpu_cfg_pkg::ubtb_size; i++) begin
            if (lookup_hits[i]) begin
                lk_entry = lk_entry | entries[i];
                lk_ctr = lk_ctr | ctrs[i];
            end
        end
    end

    ubtb_predict u_predict (
        .pc              (pc),
        .hit             (|lookup_hits),
        .fth_addr        (lk_entry.fth_addr),
        .br_en           (lk_entry.br_en),
        .br_carry        (lk_entry.br_carry),
        .br_offset       (lk_entry.br_offset),
        .br_target       (lk_entry.br_target),
        .br_tar_state    (lk_entry.br_tar_state),
        .tail_en         (lk_entry.tail_en),
        .tail_carry      (lk_entry.tail_carry),
        .tail_type       (lk_entry.tail_type),
        .tail_offset     (lk_entry.tail_offset),
        .tail_target     (lk_entry.tail_target),
        .tail_tar_state  (lk_entry.tail_tar_state),
        .ctr             (lk_ctr),
        .redirect_flush  (redirect_flush),
        .s2_redirect     (s2_redirect),
        .tage_ready      (tage_ready),
        .pred_en         (pred_en),
        .pred_hit        (pred_hit),
        .pred_taken      (pred_taken),
        .pred_target     (pred_target),
        .pred_size       (pred_size),
        .pred_br_type    (pred_br_type),
        .pred_cond_num   (pred_cond_num),
        .pred_cond_valid (pred_cond_valid),
        .pred_slot_taken (pred_slot_taken),
        .meta_ctr        (meta_ctr)
    );

    // --------------------
    // update
    // --------------------

    ubtb_replace u_replace (
        .clk    (clk),
        .rst    (rst),
        .valid  (ent_valid),
        .victim (victim)
    );

    always_comb begin
        upd_idx = '0;
        for (int i = bpu_cfg_pkg::ubtb_size - 1; i >= 0; i--) begin
            if (upd_hits[i]) begin
                upd_idx = i[bpu_cfg_pkg::ubtb_idx_w-1:0];
            end
        end
    end

    // a known block is rewritten in place
    assign write_idx = (|upd_hits) ? upd_idx : victim;

    assign upd_entry = '{
        fth_addr:       upd_fth_addr,
        br_en:          upd_br_en,
        br_carry:       upd_br_carry,
        br_offset:      upd_br_offset,
        br_target:      upd_br_target,
        br_tar_state:   upd_br_tar_state,
        tail_en:        upd_tail_en,
        tail_carry:     upd_tail_carry,
        tail_type:      upd_tail_type,
        tail_offset:    upd_tail_offset,
        tail_target:    upd_tail_target,
        tail_tar_state: upd_tail_tar_state
    };

    // carry slots predict taken on their own and need no counter
    assign train[0] = upd_alloc_slot[0] && !upd_br_carry;
    assign train[1] = upd_alloc_slot[1] && !upd_tail_carry &&
                      upd_tail_type == bpu_types_pkg::br_cond;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
            ctrs <= '{default: '0};
        end else if (update && upd_en) begin
            ent_valid[write_idx] <= 1'b1;
            for (int i = 0; i < bpu_cfg_pkg::slot_num; i++) begin
                if (train[i]) begin
                    ctrs[write_idx][i] <= sat_ctr(upd_meta_ctr[i], upd_real_taken[i]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update && upd_en) begin
            ent_tag[write_idx] <= update_tag;
            entries[write_idx] <= upd_entry;
        end
    end

    // in-place overwrite keeps every tag unique across the ways
    a_unique_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(lookup_hits) && $onehot0(upd_hits))
        else $error("multiple ubtb ways match one tag");

endmodule

//--- tb_ubtb.sv
`timescale 1ns/100ps

module tb_ubtb;

    logic                                      clk;
    logic                                      rst;
    logic [bpu_cfg_pkg::vaddr_size-1:0]        pc;
    logic                                      redirect_flush;
    logic                                      s2_redirect;
    logic                                      tage_ready;
    logic                                      update;
    logic [bpu_cfg_pkg::vaddr_size-1:0]        upd_start_addr;
    logic                                      upd_en;
    logic [bpu_cfg_pkg::prediction_width-1:0]  upd_fth_addr;
    logic                                      upd_br_en;
    logic                                      upd_br_carry;
    logic [bpu_cfg_pkg::prediction_width-1:0]  upd_br_offset;
    logic [bpu_cfg_pkg::jal_offset-1:0]        upd_br_target;
    bpu_types_pkg::tar_state_e                 upd_br_tar_state;
    logic                                      upd_tail_en;
    logic                                      upd_tail_carry;
    bpu_types_pkg::br_type_e                   upd_tail_type;
    logic [bpu_cfg_pkg::prediction_width-1:0]  upd_tail_offset;
    logic [bpu_cfg_pkg::jalr_offset-1:0]       upd_tail_target;
    bpu_types_pkg::tar_state_e                 upd_tail_tar_state;
    logic [bpu_cfg_pkg::slot_num-1:0][1:0]     upd_meta_ctr;
    logic [bpu_cfg_pkg::slot_num-1:0]          upd_real_taken;
    logic [bpu_cfg_pkg::slot_num-1:0]          upd_alloc_slot;
    logic                                      pred_en;
    logic                                      pred_hit;
    logic                                      pred_taken;
    logic [bpu_cfg_pkg::vaddr_size-1:0]        pred_target;
    logic [bpu_cfg_pkg::prediction_width-1:0]  pred_size;
    bpu_types_pkg::br_type_e                   pred_br_type;
    logic [1:0]                                pred_cond_num;
    logic [bpu_cfg_pkg::slot_num-1:0]          pred_cond_valid;
    logic [bpu_cfg_pkg::slot_num-1:0]          pred_slot_taken;
    logic [bpu_cfg_pkg::slot_num-1:0][1:0]     meta_ctr;

    // one row per case where U rows use 17 fields and L rows use 11
    logic        is_upd [0:63];
    logic [31:0] fld [0:63][0:16];
    int          n_cases;
    int          timeout_ns;
    logic        loaded;
    int          checks;
    int          errors;
    logic        case_bad;

    // blocks written so far, their last update row and their trained counters
    logic [31:0] blk_addr [0:63];
    int          blk_row [0:63];
    logic [3:0]  blk_ctr [0:63];
    int          n_blks;

    ubtb u_dut (.*);

    always #10 clk = ~clk;

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act, input int idx);
        checks++;
        if (act !== exp) begin
            errors++;
            case_bad = 1'b1;
            $display("[ERROR] case %0d %s expected %h got %h", idx, name, exp, act);
        end
    endtask

    function automatic int find_block(input logic [31:0] addr);
        for (int k = 0; k < n_blks; k++) begin
            if (blk_addr[k][31:5] == addr[31:5]) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [1:0] step_counter(input logic [1:0] c, input logic taken);
        logic [1:0] n;
        n = c;
        if (taken && c != 2'd3) begin
            n = c + 2'd1;
        end else if (!taken && c != 2'd0) begin
            n = c - 2'd1;
        end
        return n;
    endfunction

    function automatic logic [1:0] expected_cond_valid(input int r, input logic [1:0] taken);
        logic [1:0] conds;
        conds = {fld[r][8][0] && fld[r][10][2:0] == bpu_types_pkg::br_cond, fld[r][3][0]};
        // a taken tail conditional ahead of the branch leaves only the tail in the block
        if (taken[1] && fld[r][5][2:0] > fld[r][11][2:0]) begin
            conds = 2'b10;
        end
        return conds;
    endfunction

    task automatic record_update(input int i);
        int b;
        b = find_block(fld[i][0]);
        if (b < 0) begin
            b = n_blks;
            blk_addr[b] = fld[i][0];
            blk_ctr[b] = 4'h0;
            n_blks++;
        end
        blk_row[b] = i;
        if (fld[i][16][0] && !fld[i][4][0]) begin
            blk_ctr[b][1:0] = step_counter(fld[i][14][1:0], fld[i][15][0]);
        end
        // the tail slot trains only while it holds a conditional
        if (fld[i][16][1] && !fld[i][9][0] && fld[i][10][2:0] == bpu_types_pkg::br_cond) begin
            blk_ctr[b][3:2] = step_counter(fld[i][14][3:2], fld[i][15][1]);
        end
    endtask

    task automatic read_cases;
        int          fd;
        int          code;
        int          n_fields;
        logic [7:0]  kind;
        logic [31:0] value;
        logic [8*160-1:0] rest;
        n_cases = 0;
        fd = $fopen("ubtb_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open ubtb_cases.txt");
            errors++;
        end else begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1) begin
                if (kind == "#") begin
                    code = $fgets(rest, fd);
                end else if ((kind == "U" || kind == "L") && n_cases < 64) begin
                    is_upd[n_cases] = (kind == "U");
                    n_fields = (kind == "U") ? 17 : 11;
                    for (int k = 0; k < n_fields; k++) begin
                        code = $fscanf(fd, "%h", value);
                        fld[n_cases][k] = value;
                    end
                    n_cases++;
                end else begin
                    $display("case line with kind '%c' could not be used", kind);
                    errors++;
                end
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_update(input int i);
        upd_start_addr = fld[i][0];
        upd_en = fld[i][1][0];
        upd_fth_addr = fld[i][2][2:0];
        upd_br_en = fld[i][3][0];
        upd_br_carry = fld[i][4][0];
        upd_br_offset = fld[i][5][2:0];
        upd_br_target = fld[i][6][11:0];
        upd_br_tar_state = bpu_types_pkg::tar_state_e'(fld[i][7][1:0]);
        upd_tail_en = fld[i][8][0];
        upd_tail_carry = fld[i][9][0];
        upd_tail_type = bpu_types_pkg::br_type_e'(fld[i][10][2:0]);
        upd_tail_offset = fld[i][11][2:0];
        upd_tail_target = fld[i][12][19:0];
        upd_tail_tar_state = bpu_types_pkg::tar_state_e'(fld[i][13][1:0]);
        upd_meta_ctr = fld[i][14][3:0];
        upd_real_taken = fld[i][15][1:0];
        upd_alloc_slot = fld[i][16][1:0];
        update = 1'b1;
        if (fld[i][1][0]) begin
            record_update(i);
        end
        $display("case %0d update of block %h applied", i, fld[i][0]);
    endtask

    task automatic run_lookup(input int i);
        logic exp_en;
        int   blk;
        update = 1'b0;
        pc = fld[i][0];
        redirect_flush = fld[i][1][0];
        s2_redirect = fld[i][2][0];
        tage_ready = fld[i][3][0];
        case_bad = 1'b0;
        #10;
        // pred_en needs both redirects low and tage_ready high
        exp_en = !fld[i][1][0] && !fld[i][2][0] && fld[i][3][0];
        compare_field("pred_en", exp_en, pred_en, i);
        compare_field("pred_hit", fld[i][4], pred_hit, i);
        compare_field("pred_taken", fld[i][5], pred_taken, i);
        compare_field("pred_target", fld[i][6], pred_target, i);
        compare_field("pred_size", fld[i][7], pred_size, i);
        compare_field("pred_br_type", fld[i][8], pred_br_type, i);
        compare_field("pred_cond_num", fld[i][9], pred_cond_num, i);
        compare_field("pred_slot_taken", fld[i][10], pred_slot_taken, i);
        blk = find_block(fld[i][0]);
        if (fld[i][4][0] && blk >= 0) begin
            compare_field("pred_cond_valid",
                          expected_cond_valid(blk_row[blk], fld[i][10][1:0]),
                          pred_cond_valid, i);
            compare_field("meta_ctr", blk_ctr[blk], meta_ctr, i);
        end else begin
            compare_field("pred_cond_valid", 32'h0, pred_cond_valid, i);
        end
        if (case_bad) begin
            $display("case %0d lookup %h mismatch", i, fld[i][0]);
        end else begin
            $display("case %0d lookup %h ok", i, fld[i][0]);
        end
    endtask

    // --------------------
    // watchdog
    // --------------------

    initial begin
        wait (loaded === 1'b1);
        #(timeout_ns);
        $display("timeout after %0d ns, the cases did not finish", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int idle;
        clk = 1'b0;
        rst = 1'b1;
        pc = '0;
        redirect_flush = 1'b0;
        s2_redirect = 1'b0;
        tage_ready = 1'b1;
        update = 1'b0;
        upd_start_addr = '0;
        upd_en = 1'b0;
        upd_fth_addr = '0;
        upd_br_en = 1'b0;
        upd_br_carry = 1'b0;
        upd_br_offset = '0;
        upd_br_target = '0;
        upd_br_tar_state = bpu_types_pkg::tar_normal;
        upd_tail_en = 1'b0;
        upd_tail_carry = 1'b0;
        upd_tail_type = bpu_types_pkg::br_cond;
        upd_tail_offset = '0;
        upd_tail_target = '0;
        upd_tail_tar_state = bpu_types_pkg::tar_normal;
        upd_meta_ctr = '0;
        upd_real_taken = '0;
        upd_alloc_slot = '0;
        loaded = 1'b0;
        checks = 0;
        errors = 0;
        n_blks = 0;
        void'($urandom(32'hb28d));
        read_cases();
        timeout_ns = n_cases * 6 * 20 + 8 * 20;
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            idle = $urandom % 4;
            repeat (idle) begin
                @(posedge clk);
                #1;
                update = 1'b0;
                pc = $urandom & 32'hffff_fffc;
            end
            @(posedge clk);
            #1;
            if (is_upd[i]) begin
                apply_update(i);
            end else begin
                run_lookup(i);
            end
        end
        @(posedge clk);
        #1 update = 1'b0;
        $display("%0d cases, %0d checks, %0d errors", n_cases, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- ubtb_cases.txt
# U addr en fth br_en br_carry br_off br_tgt br_st tail_en tail_carry tail_type tail_off tail_tgt tail_st meta real alloc
# L pc flush s2 tage_ready hit taken target size br_type cond_num slot_taken (all hex)
L 00600000 0 0 1 0 0 00600020 7 0 0 0
U 00600100 1 7 0 0 0 000 0 1 0 1 3 12340 0 0 0 0
U 00600200 1 7 0 0 0 000 0 1 0 1 5 00100 1 0 0 0
U 00600300 1 7 0 0 0 000 0 1 0 1 7 ffff0 2 0 0 0
L 00600100 0 0 1 1 1 00624680 3 1 0 0
L 00600200 0 0 1 1 1 00800200 5 1 0 0
L 00600300 0 0 1 1 1 005fffe0 7 1 0 0
L 00600108 0 0 1 1 1 00624680 3 1 0 0
U 00600400 1 6 1 0 2 456 0 0 0 0 0 00000 0 0 0 0
L 00600400 0 0 1 1 0 0060041c 6 0 1 0
U 00600400 1 6 1 0 2 456 0 0 0 0 0 00000 0 1 1 1
U 00600400 1 6 1 0 2 456 0 0 0 0 0 00000 0 1 1 1
L 00600400 0 0 1 1 1 006008ac 2 0 1 1
U 00600400 1 6 1 0 2 456 0 0 0 0 0 00000 0 0 0 0
L 00600400 0 0 1 1 1 006008ac 2 0 1 1
U 00600500 1 7 1 1 4 800 1 0 0 0 0 00000 0 0 0 1
L 00600500 0 0 1 1 1 00603000 4 0 1 1
U 00600600 1 7 1 0 5 111 0 1 0 0 2 00222 0 5 3 3
L 00600600 0 0 1 1 1 00600444 2 0 1 3
U 00600700 1 7 1 0 3 0a0 0 1 0 0 3 00333 0 5 3 3
L 00600700 0 0 1 1 1 00600140 3 0 2 3
U 00600100 1 7 0 0 0 000 0 1 0 1 6 00abc 0 0 0 0
L 00600104 0 0 1 1 1 00601578 6 1 0 0
L 00600f00 0 0 1 0 0 00600f20 7 0 0 0
L 00600100 1 0 1 1 1 00601578 6 1 0 0
L 00600100 0 1 1 1 1 00601578 6 1 0 0
L 00600100 0 0 0 1 1 00601578 6 1 0 0

//--- all.f
bpu_cfg_pkg.sv
bpu_types_pkg.sv
ubtb_replace.sv
ubtb_predict.sv
ubtb.sv
tb_ubtb.sv
